// ==== hw/bitcore_settings.svh ====
`ifndef BITCORE_SETTINGS_SVH
`define BITCORE_SETTINGS_SVH

// Address of the first fetch after reset
`define BITCORE_RESET_PC 32'h0000_0000

// Architectural registers, x0 included
`define BITCORE_NUM_REGS 32

`endif

// ==== hw/bitcore_isa_pkg.sv ====
`default_nettype none

package bitcore_isa_pkg;

   typedef enum logic [3:0] {
      OP_ILLEGAL,
      OP_ADDI,
      OP_ADD,
      OP_SUB,
      OP_AND,
      OP_OR,
      OP_XOR,
      OP_LUI,
      OP_BEQ,
      OP_BNE,
      OP_JAL,
      OP_LW,
      OP_SW
   } opcode_e;

   typedef enum logic [2:0] {
      FETCH,
      READ,
      EXEC,
      MEM,
      WRITEBACK
   } exec_state_e;

   // Boolean unit selector, BOOL_NONE leaves the adder on the result
   typedef enum logic [1:0] {
      BOOL_NONE,
      BOOL_AND,
      BOOL_OR,
      BOOL_XOR
   } bool_op_e;

   typedef struct packed {
      opcode_e     op;
      logic [4:0]  rd;
      logic [4:0]  rs1;
      logic [4:0]  rs2;
      logic [31:0] imm;
      logic        wr_rd;
      logic        imm_b;
      logic        sub;
      bool_op_e    bool_op;
   } decoded_t;

endpackage

`default_nettype wire

// ==== hw/bitcore_bus_pkg.sv ====
`default_nettype none

package bitcore_bus_pkg;

   // Instruction fetch request
   typedef struct packed {
      logic [31:0] adr;
      logic        cyc;
   } ibus_req_t;

   // Data request, one word per access
   typedef struct packed {
      logic [31:0] adr;
      logic [31:0] dat;
      logic        we;
      logic        cyc;
   } dbus_req_t;

endpackage

`default_nettype wire

// ==== hw/bitcore_decode.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "bitcore_settings.svh"

module bitcore_decode (
   input  wire                          clk,
   input  wire                          i_rst_n,
   input  wire [31:0]                   i_ibus_rdt,
   input  wire                          i_ibus_ack,
   input  wire                          i_dbus_ack,
   input  wire                          i_alu_eq,
   output bitcore_isa_pkg::decoded_t    o_dec,
   output bitcore_isa_pkg::exec_state_e o_state,
   output logic                         o_exec_en,
   output logic                         o_last_bit,
   output logic                         o_imm_bit,
   output logic                         o_branch_taken
);

   logic [4:0]  cnt;
   logic [31:0] imm_sh;
   logic        is_mem;

   function automatic bitcore_isa_pkg::decoded_t decode_word(input logic [31:0] w);
      bitcore_isa_pkg::decoded_t d;
      d = '0;
      d.rd = w[11:7];
      d.rs1 = w[19:15];
      d.rs2 = w[24:20];
      d.imm = {{20{w[31]}}, w[31:20]};
      case (w[6:0])
         7'b0010011: begin
            if (w[14:12] == 3'b000) begin
               d.op = bitcore_isa_pkg::OP_ADDI;
               d.wr_rd = 1'b1;
               d.imm_b = 1'b1;
            end
         end
         7'b0110011: begin
            d.wr_rd = 1'b1;
            case ({w[30], w[14:12]})
               4'b0000: d.op = bitcore_isa_pkg::OP_ADD;
               4'b1000: begin
                  d.op = bitcore_isa_pkg::OP_SUB;
                  d.sub = 1'b1;
               end
               4'b0111: begin
                  d.op = bitcore_isa_pkg::OP_AND;
                  d.bool_op = bitcore_isa_pkg::BOOL_AND;
               end
               4'b0110: begin
                  d.op = bitcore_isa_pkg::OP_OR;
                  d.bool_op = bitcore_isa_pkg::BOOL_OR;
               end
               4'b0100: begin
                  d.op = bitcore_isa_pkg::OP_XOR;
                  d.bool_op = bitcore_isa_pkg::BOOL_XOR;
               end
               default: d.wr_rd = 1'b0;
            endcase
         end
         7'b0110111: begin
            d.op = bitcore_isa_pkg::OP_LUI;
            d.wr_rd = 1'b1;
            d.imm_b = 1'b1;
            d.imm = {w[31:12], 12'd0};
         end
         7'b1100011: begin
            d.imm = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            if (w[14:12] == 3'b000) begin
               d.op = bitcore_isa_pkg::OP_BEQ;
            end else if (w[14:12] == 3'b001) begin
               d.op = bitcore_isa_pkg::OP_BNE;
            end
         end
         7'b1101111: begin
            d.op = bitcore_isa_pkg::OP_JAL;
            d.wr_rd = 1'b1;
            d.imm = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
         end
         7'b0000011: begin
            if (w[14:12] == 3'b010) begin
               d.op = bitcore_isa_pkg::OP_LW;
               d.wr_rd = 1'b1;
               d.imm_b = 1'b1;
            end
         end
         7'b0100011: begin
            if (w[14:12] == 3'b010) begin
               d.op = bitcore_isa_pkg::OP_SW;
               d.imm_b = 1'b1;
               d.imm = {{20{w[31]}}, w[31:25], w[11:7]};
            end
         end
         default: ;
      endcase
      // Register fields past the implemented set turn the word into a no-op
      if (int'(d.rd) >= `BITCORE_NUM_REGS || int'(d.rs1) >= `BITCORE_NUM_REGS) begin
         d.op = bitcore_isa_pkg::OP_ILLEGAL;
         d.wr_rd = 1'b0;
      end
      return d;
   endfunction

   assign is_mem = (o_dec.op == bitcore_isa_pkg::OP_LW) || (o_dec.op == bitcore_isa_pkg::OP_SW);
   assign o_exec_en = (o_state == bitcore_isa_pkg::EXEC) || (o_state == bitcore_isa_pkg::WRITEBACK);
   assign o_last_bit = o_exec_en && (cnt == 5'd31);
   assign o_imm_bit = imm_sh[0];

   always_comb begin
      o_branch_taken = 1'b0;
      if (o_last_bit && o_state == bitcore_isa_pkg::EXEC) begin
         o_branch_taken = (o_dec.op == bitcore_isa_pkg::OP_BEQ && i_alu_eq) ||
                          (o_dec.op == bitcore_isa_pkg::OP_BNE && !i_alu_eq);
      end
   end

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         o_state <= bitcore_isa_pkg::FETCH;
         o_dec <= '0;
         cnt <= '0;
      end else begin
         // Wraps back to zero after each 32-bit pass
         if (o_exec_en) begin
            cnt <= cnt + 5'd1;
         end
         case (o_state)
            bitcore_isa_pkg::FETCH: begin
               if (i_ibus_ack) begin
                  o_dec <= decode_word(i_ibus_rdt);
                  o_state <= bitcore_isa_pkg::READ;
               end
            end
            bitcore_isa_pkg::READ: o_state <= bitcore_isa_pkg::EXEC;
            bitcore_isa_pkg::EXEC: begin
               if (o_last_bit) begin
                  o_state <= is_mem ? bitcore_isa_pkg::MEM : bitcore_isa_pkg::FETCH;
               end
            end
            bitcore_isa_pkg::MEM: begin
               if (i_dbus_ack) begin
                  o_state <= (o_dec.op == bitcore_isa_pkg::OP_LW) ?
                             bitcore_isa_pkg::WRITEBACK : bitcore_isa_pkg::FETCH;
               end
            end
            bitcore_isa_pkg::WRITEBACK: begin
               if (o_last_bit) begin
                  o_state <= bitcore_isa_pkg::FETCH;
               end
            end
            default: o_state <= bitcore_isa_pkg::FETCH;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (o_state == bitcore_isa_pkg::READ) begin
         imm_sh <= o_dec.imm;
      end else if (o_exec_en && o_state == bitcore_isa_pkg::EXEC) begin
         imm_sh <= {imm_sh[31], imm_sh[31:1]};
      end
   end

endmodule

`default_nettype wire

// ==== hw/bitcore_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "bitcore_settings.svh"

module bitcore_regfile (
   input  wire       clk,
   input  wire       i_rst_n,
   input  wire       i_read,
   input  wire       i_exec_en,
   input  wire [4:0] i_rs1_addr,
   input  wire [4:0] i_rs2_addr,
   input  wire [4:0] i_rd_addr,
   input  wire       i_rd_we,
   input  wire       i_rd_bit,
   input  wire       i_commit,
   output logic      o_rs1_bit,
   output logic      o_rs2_bit
);

   logic [31:0] regs [`BITCORE_NUM_REGS];
   logic [31:0] rs1_sh;
   logic [31:0] rs2_sh;
   logic [31:0] rd_sh;
   logic [31:0] rd_word;

   // Word as it stands once the current bit is shifted in
   assign rd_word = {i_rd_bit, rd_sh[31:1]};
   assign o_rs1_bit = rs1_sh[0];
   assign o_rs2_bit = rs2_sh[0];

   always_ff @(posedge clk) begin
      if (i_read) begin
         rs1_sh <= (i_rs1_addr == 5'd0) ? 32'd0 : regs[i_rs1_addr];
         rs2_sh <= (i_rs2_addr == 5'd0) ? 32'd0 : regs[i_rs2_addr];
      end else if (i_exec_en) begin
         rs1_sh <= {1'b0, rs1_sh[31:1]};
         rs2_sh <= {1'b0, rs2_sh[31:1]};
      end
      if (i_exec_en) begin
         rd_sh <= rd_word;
      end
      if (i_rst_n && i_commit && i_rd_we && i_rd_addr != 5'd0) begin
         regs[i_rd_addr] <= rd_word;
      end
   end

endmodule

`default_nettype wire

// ==== hw/bitcore_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module bitcore_alu (
   input  wire                       clk,
   input  wire                       i_rst_n,
   input  wire                       i_exec_en,
   input  wire                       i_first_bit,
   input  wire bitcore_isa_pkg::decoded_t i_dec,
   input  wire                       i_rs1_bit,
   input  wire                       i_imm_bit,
   input  wire                       i_rs2_bit,
   output logic                      o_rd_bit,
   output logic                      o_eq
);

   logic op_b;
   logic b_inv;
   logic carry_in;
   logic carry_r;
   logic sum;
   logic eq_r;

   assign op_b = i_dec.imm_b ? i_imm_bit : i_rs2_bit;
   assign b_inv = op_b ^ i_dec.sub;
   // Subtract seeds a one into bit 0 to finish the two's complement
   assign carry_in = i_first_bit ? i_dec.sub : carry_r;
   assign sum = i_rs1_bit ^ b_inv ^ carry_in;
   // Equal so far, current bit included
   assign o_eq = (i_rs1_bit == op_b) && (i_first_bit || eq_r);

   always_comb begin
      case (i_dec.bool_op)
         bitcore_isa_pkg::BOOL_AND: o_rd_bit = i_rs1_bit & op_b;
         bitcore_isa_pkg::BOOL_OR:  o_rd_bit = i_rs1_bit | op_b;
         bitcore_isa_pkg::BOOL_XOR: o_rd_bit = i_rs1_bit ^ op_b;
         default: o_rd_bit = (i_dec.op == bitcore_isa_pkg::OP_LUI) ? i_imm_bit : sum;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         carry_r <= 1'b0;
         eq_r <= 1'b1;
      end else if (i_exec_en) begin
         carry_r <= (i_rs1_bit & b_inv) | (carry_in & (i_rs1_bit ^ b_inv));
         eq_r <= o_eq;
      end
   end

endmodule

`default_nettype wire

// ==== hw/bitcore_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "bitcore_settings.svh"

module bitcore_ctrl (
   input  wire                          clk,
   input  wire                          i_rst_n,
   input  wire bitcore_isa_pkg::exec_state_e i_state,
   input  wire                          i_exec_en,
   input  wire                          i_last_bit,
   input  wire bitcore_isa_pkg::decoded_t    i_dec,
   input  wire                          i_imm_bit,
   input  wire                          i_branch_taken,
   input  wire                          i_ibus_ack,
   output bitcore_bus_pkg::ibus_req_t   o_ibus,
   output logic                         o_link_bit
);

   logic [31:0] pc;
   logic [31:0] target_sh;
   logic [2:0]  four_sh;
   logic        cyc_r;
   logic        c4_r;
   logic        ci_r;
   logic        sum4;
   logic        sumi;
   logic        shift_en;
   logic        take;

   // PC rotates through itself during execute, so the fetch address is
   // only meaningful while cyc is high
   assign shift_en = i_exec_en && (i_state == bitcore_isa_pkg::EXEC);
   assign sum4 = pc[0] ^ four_sh[0] ^ c4_r;
   assign sumi = pc[0] ^ i_imm_bit ^ ci_r;
   assign take = i_branch_taken || (i_dec.op == bitcore_isa_pkg::OP_JAL);
   assign o_link_bit = sum4;
   assign o_ibus = '{adr: pc, cyc: cyc_r};

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         pc <= `BITCORE_RESET_PC;
         cyc_r <= 1'b0;
         four_sh <= 3'd0;
         c4_r <= 1'b0;
         ci_r <= 1'b0;
      end else begin
         if (cyc_r && i_ibus_ack) begin
            cyc_r <= 1'b0;
         end else if (i_state == bitcore_isa_pkg::FETCH) begin
            cyc_r <= 1'b1;
         end
         if (i_state == bitcore_isa_pkg::READ) begin
            // Constant 4 as a serial stream with its one in bit 2
            four_sh <= 3'b100;
            c4_r <= 1'b0;
            ci_r <= 1'b0;
         end else if (shift_en) begin
            four_sh <= {1'b0, four_sh[2:1]};
            c4_r <= (pc[0] & four_sh[0]) | (c4_r & (pc[0] ^ four_sh[0]));
            ci_r <= (pc[0] & i_imm_bit) | (ci_r & (pc[0] ^ i_imm_bit));
            if (i_last_bit && take) begin
               pc <= {sumi, target_sh[31:1]};
            end else begin
               pc <= {sum4, pc[31:1]};
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (shift_en) begin
         target_sh <= {sumi, target_sh[31:1]};
      end
   end

endmodule

`default_nettype wire

// ==== hw/bitcore_mem_if.sv ====
`timescale 1ns/1ps
`default_nettype none

module bitcore_mem_if (
   input  wire                          clk,
   input  wire                          i_rst_n,
   input  wire bitcore_isa_pkg::exec_state_e i_state,
   input  wire                          i_exec_en,
   input  wire                          i_is_store,
   input  wire                          i_addr_bit,
   input  wire                          i_rs2_bit,
   input  wire [31:0]                   i_dbus_rdt,
   input  wire                          i_dbus_ack,
   output bitcore_bus_pkg::dbus_req_t   o_dbus,
   output logic                         o_load_bit
);

   logic [31:0] adr_sh;
   logic [31:0] dat_sh;
   logic [31:0] rdt_sh;
   logic        cyc_r;

   assign o_dbus = '{adr: {adr_sh[31:2], 2'b00}, dat: dat_sh, we: i_is_store, cyc: cyc_r};
   assign o_load_bit = rdt_sh[0];

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         cyc_r <= 1'b0;
      end else if (cyc_r && i_dbus_ack) begin
         cyc_r <= 1'b0;
      end else if (i_state == bitcore_isa_pkg::MEM) begin
         cyc_r <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      // Address is the ALU sum, store data comes straight from rs2
      if (i_exec_en && i_state == bitcore_isa_pkg::EXEC) begin
         adr_sh <= {i_addr_bit, adr_sh[31:1]};
         dat_sh <= {i_rs2_bit, dat_sh[31:1]};
      end
      if (cyc_r && i_dbus_ack) begin
         rdt_sh <= i_dbus_rdt;
      end else if (i_exec_en && i_state == bitcore_isa_pkg::WRITEBACK) begin
         rdt_sh <= {1'b0, rdt_sh[31:1]};
      end
   end

endmodule

`default_nettype wire

// ==== hw/bitcore_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module bitcore_top (
   input  wire                        clk,
   input  wire                        i_rst_n,
   input  wire [31:0]                 i_ibus_rdt,
   input  wire                        i_ibus_ack,
   input  wire [31:0]                 i_dbus_rdt,
   input  wire                        i_dbus_ack,
   output bitcore_bus_pkg::ibus_req_t o_ibus,
   output bitcore_bus_pkg::dbus_req_t o_dbus
);

   bitcore_isa_pkg::decoded_t    dec;
   bitcore_isa_pkg::exec_state_e state;
   logic exec_en;
   logic last_bit;
   logic imm_bit;
   logic branch_taken;
   logic alu_eq;
   logic rs1_bit;
   logic rs2_bit;
   logic alu_rd_bit;
   logic link_bit;
   logic load_bit;
   logic rd_bit;
   logic first_bit;
   logic commit;

   // High on the first execute cycle, which always follows READ
   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         first_bit <= 1'b0;
      end else begin
         first_bit <= (state == bitcore_isa_pkg::READ);
      end
   end

   // Load data in write-back, link value for JAL, ALU otherwise
   assign rd_bit = (state == bitcore_isa_pkg::WRITEBACK) ? load_bit :
                   (dec.op == bitcore_isa_pkg::OP_JAL) ? link_bit : alu_rd_bit;
   assign commit = last_bit &&
                   (state == bitcore_isa_pkg::WRITEBACK || dec.op != bitcore_isa_pkg::OP_LW);

   bitcore_decode decode_i (
      .clk            (clk),
      .i_rst_n        (i_rst_n),
      .i_ibus_rdt     (i_ibus_rdt),
      .i_ibus_ack     (i_ibus_ack & o_ibus.cyc),
      .i_dbus_ack     (i_dbus_ack & o_dbus.cyc),
      .i_alu_eq       (alu_eq),
      .o_dec          (dec),
      .o_state        (state),
      .o_exec_en      (exec_en),
      .o_last_bit     (last_bit),
      .o_imm_bit      (imm_bit),
      .o_branch_taken (branch_taken)
   );

   bitcore_regfile regfile_i (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_read     (state == bitcore_isa_pkg::READ),
      .i_exec_en  (exec_en),
      .i_rs1_addr (dec.rs1),
      .i_rs2_addr (dec.rs2),
      .i_rd_addr  (dec.rd),
      .i_rd_we    (dec.wr_rd),
      .i_rd_bit   (rd_bit),
      .i_commit   (commit),
      .o_rs1_bit  (rs1_bit),
      .o_rs2_bit  (rs2_bit)
   );

   bitcore_alu alu_i (
      .clk         (clk),
      .i_rst_n     (i_rst_n),
      .i_exec_en   (exec_en),
      .i_first_bit (first_bit),
      .i_dec       (dec),
      .i_rs1_bit   (rs1_bit),
      .i_imm_bit   (imm_bit),
      .i_rs2_bit   (rs2_bit),
      .o_rd_bit    (alu_rd_bit),
      .o_eq        (alu_eq)
   );

   bitcore_ctrl ctrl_i (
      .clk            (clk),
      .i_rst_n        (i_rst_n),
      .i_state        (state),
      .i_exec_en      (exec_en),
      .i_last_bit     (last_bit),
      .i_dec          (dec),
      .i_imm_bit      (imm_bit),
      .i_branch_taken (branch_taken),
      .i_ibus_ack     (i_ibus_ack),
      .o_ibus         (o_ibus),
      .o_link_bit     (link_bit)
   );

   bitcore_mem_if mem_if_i (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_state    (state),
      .i_exec_en  (exec_en),
      .i_is_store (dec.op == bitcore_isa_pkg::OP_SW),
      .i_addr_bit (alu_rd_bit),
      .i_rs2_bit  (rs2_bit),
      .i_dbus_rdt (i_dbus_rdt),
      .i_dbus_ack (i_dbus_ack),
      .o_dbus     (o_dbus),
      .o_load_bit (load_bit)
   );

endmodule

`default_nettype wire

// ==== sim/bitcore_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module bitcore_properties (
   input wire                             clk,
   input wire                             i_rst_n,
   input wire                             i_ibus_ack,
   input wire                             i_dbus_ack,
   input wire bitcore_bus_pkg::ibus_req_t i_ibus,
   input wire bitcore_bus_pkg::dbus_req_t i_dbus
);

   int unsigned fail_cnt = 0;

   // Both buses idle while reset is held
   cyc_low_in_reset: assert property (@(posedge clk)
      !i_rst_n |=> !i_ibus.cyc && !i_dbus.cyc)
      else begin
         fail_cnt++;
         $error("bus cycle active during reset");
      end

   first_fetch: assert property (@(posedge clk) $rose(i_rst_n) |=> i_ibus.cyc)
      else begin
         fail_cnt++;
         $error("no fetch on the first edge after reset");
      end

   ibus_stable: assert property (@(posedge clk) disable iff (!i_rst_n)
      i_ibus.cyc && !i_ibus_ack |=> i_ibus.cyc && $stable(i_ibus.adr))
      else begin
         fail_cnt++;
         $error("ibus request changed before ack");
      end

   dbus_stable: assert property (@(posedge clk) disable iff (!i_rst_n)
      i_dbus.cyc && !i_dbus_ack |=>
         i_dbus.cyc && $stable({i_dbus.adr, i_dbus.dat, i_dbus.we}))
      else begin
         fail_cnt++;
         $error("dbus request changed before ack");
      end

   ibus_aligned: assert property (@(posedge clk) disable iff (!i_rst_n)
      i_ibus.cyc |-> i_ibus.adr[1:0] == 2'b00)
      else begin
         fail_cnt++;
         $error("ibus address not word aligned");
      end

   ibus_release: assert property (@(posedge clk) disable iff (!i_rst_n)
      i_ibus.cyc && i_ibus_ack |=> !i_ibus.cyc)
      else begin
         fail_cnt++;
         $error("ibus cyc still high after ack");
      end

   dbus_release: assert property (@(posedge clk) disable iff (!i_rst_n)
      i_dbus.cyc && i_dbus_ack |=> !i_dbus.cyc)
      else begin
         fail_cnt++;
         $error("dbus cyc still high after ack");
      end

endmodule

bind bitcore_top bitcore_properties props_i (
   .clk        (clk),
   .i_rst_n    (i_rst_n),
   .i_ibus_ack (i_ibus_ack),
   .i_dbus_ack (i_dbus_ack),
   .i_ibus     (o_ibus),
   .i_dbus     (o_dbus)
);

`default_nettype wire

// ==== sim/bitcore_tb.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "bitcore_settings.svh"

module bitcore_tb;

   localparam logic [31:0] DATA_BASE = 32'h0000_1000;
   localparam int MAX_ACK_DELAY = 3;

   typedef struct packed {
      logic [31:0] adr;
      logic [31:0] dat;
   } store_t;

   logic        clk = 1'b0;
   logic        rst_n = 1'b0;
   logic [31:0] ibus_rdt = '0;
   logic        ibus_ack = 1'b0;
   logic [31:0] dbus_rdt = '0;
   logic        dbus_ack = 1'b0;
   bitcore_bus_pkg::ibus_req_t ibus_req;
   bitcore_bus_pkg::dbus_req_t dbus_req;

   logic [31:0] rom [0:63];
   logic [31:0] dram [0:255];
   logic [31:0] fetch_q [$];
   store_t      store_q [$];
   string       name_q [$];
   logic [31:0] asm_pc;
   logic [31:0] end_pc;
   logic [15:0] lfsr = 16'd50943;
   int          ibus_wait = -1;
   int          dbus_wait = -1;
   int          errs = 0;
   int          reset_errs = 0;
   int          fetch_errs = 0;
   int          tests_run = 0;
   int          tests_failed = 0;
   int          stores_seen = 0;
   int          limit_cycles = 0;
   int          prop_fails;
   bit          fetch_seen = 1'b0;
   bit          done = 1'b0;

   bitcore_top bitcore_top_i (
      .clk        (clk),
      .i_rst_n    (rst_n),
      .i_ibus_rdt (ibus_rdt),
      .i_ibus_ack (ibus_ack),
      .i_dbus_rdt (dbus_rdt),
      .i_dbus_ack (dbus_ack),
      .o_ibus     (ibus_req),
      .o_dbus     (dbus_req)
   );

   always #2 clk = ~clk;

   // RV32I encodings
   function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                         logic [4:0] rd, logic [6:0] opc);
      return {imm, rs1, f3, rd, opc};
   endfunction

   function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                         logic [2:0] f3, logic [4:0] rd);
      return {f7, rs2, rs1, f3, rd, 7'b0110011};
   endfunction

   function automatic logic [31:0] enc_s(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
      return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
   endfunction

   function automatic logic [31:0] enc_b(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                         logic [2:0] f3);
      return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
   endfunction

   function automatic logic [31:0] enc_j(logic [20:0] imm, logic [4:0] rd);
      return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
   endfunction

   function automatic logic [31:0] enc_u(logic [19:0] imm, logic [4:0] rd);
      return {imm, rd, 7'b0110111};
   endfunction

   function automatic logic [31:0] sext12(logic [11:0] v);
      return {{20{v[11]}}, v};
   endfunction

   function automatic logic [31:0] fill_word(logic [31:0] adr);
      return (adr * 32'h9E37_79B9) ^ {adr[15:0], adr[31:16]};
   endfunction

   // Two LFSR steps per delay over taps 16, 14, 13 and 11
   function automatic logic [1:0] draw_delay();
      logic [1:0] v;
      v = '0;
      for (int i = 0; i < 2; i++) begin
         lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
         v = {v[0], lfsr[0]};
      end
      return v;
   endfunction

   task automatic emit(input logic [31:0] w, input bit runs);
      rom[asm_pc[7:2]] = w;
      if (runs) begin
         fetch_q.push_back(asm_pc);
      end
      asm_pc = asm_pc + 32'd4;
   endtask

   task automatic load_const(input logic [4:0] rd, input logic [31:0] v);
      logic [31:0] t;
      // Upper part rounded so the signed low twelve bits add back to v
      t = v + 32'h800;
      emit(enc_u(t[31:12], rd), 1'b1);
      emit(enc_i(v[11:0], rd, 3'b000, rd, 7'b0010011), 1'b1);
   endtask

   task automatic store_word(input logic [4:0] rs2, input logic [11:0] off, input string name,
                             input logic [31:0] exp);
      emit(enc_s(off, rs2, 5'd10), 1'b1);
      store_q.push_back('{adr: DATA_BASE + {20'd0, off}, dat: exp});
      name_q.push_back(name);
   endtask

   task automatic build_program();
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] jal_pc;
      logic [31:0] stray;
      a = 32'h89AB_CDEF;
      b = 32'h0F0F_1234;
      stray = enc_s(12'h07C, 5'd1, 5'd10);
      // Unused words decode as no-ops
      for (int i = 0; i < 64; i++) begin
         rom[i] = '0;
      end
      for (int i = 0; i < 256; i++) begin
         dram[i] = fill_word(DATA_BASE + 32'(i) * 32'd4);
      end
      asm_pc = `BITCORE_RESET_PC;
      emit(enc_u(DATA_BASE[31:12], 5'd10), 1'b1);
      load_const(5'd1, a);
      load_const(5'd2, b);
      store_word(5'd1, 12'd0, "lui_addi", a);
      emit(enc_i(12'hF9C, 5'd1, 3'b000, 5'd3, 7'b0010011), 1'b1);
      store_word(5'd3, 12'd4, "addi", a + sext12(12'hF9C));
      emit(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3), 1'b1);
      store_word(5'd3, 12'd8, "add", a + b);
      emit(enc_r(7'h20, 5'd2, 5'd1, 3'b000, 5'd3), 1'b1);
      store_word(5'd3, 12'd12, "sub", a - b);
      emit(enc_i(12'd1, 5'd0, 3'b000, 5'd4, 7'b0010011), 1'b1);
      emit(enc_r(7'h20, 5'd4, 5'd0, 3'b000, 5'd3), 1'b1);
      store_word(5'd3, 12'd16, "sub_borrow", 32'd0 - 32'd1);
      emit(enc_r(7'h00, 5'd2, 5'd1, 3'b111, 5'd3), 1'b1);
      store_word(5'd3, 12'd20, "and", a & b);
      emit(enc_r(7'h00, 5'd2, 5'd1, 3'b110, 5'd3), 1'b1);
      store_word(5'd3, 12'd24, "or", a | b);
      emit(enc_r(7'h00, 5'd2, 5'd1, 3'b100, 5'd3), 1'b1);
      store_word(5'd3, 12'd28, "xor", a ^ b);
      emit(enc_u(20'hFEDCB, 5'd3), 1'b1);
      store_word(5'd3, 12'd32, "lui", {20'hFEDCB, 12'h000});
      emit(enc_i(12'd5, 5'd1, 3'b000, 5'd0, 7'b0010011), 1'b1);
      store_word(5'd0, 12'd36, "x0_write", 32'd0);
      // Taken branches skip a stray store, so the trace holds PC+8
      emit(enc_b(13'd8, 5'd1, 5'd1, 3'b000), 1'b1);
      emit(stray, 1'b0);
      emit(enc_b(13'd8, 5'd2, 5'd1, 3'b000), 1'b1);
      emit(enc_b(13'd8, 5'd2, 5'd1, 3'b001), 1'b1);
      emit(stray, 1'b0);
      emit(enc_b(13'd8, 5'd1, 5'd1, 3'b001), 1'b1);
      jal_pc = asm_pc;
      emit(enc_j(21'd8, 5'd6), 1'b1);
      emit(stray, 1'b0);
      store_word(5'd6, 12'd40, "jal_link", jal_pc + 32'd4);
      emit(enc_i(12'h100, 5'd10, 3'b010, 5'd7, 7'b0000011), 1'b1);
      emit(enc_i(12'd1, 5'd7, 3'b000, 5'd7, 7'b0010011), 1'b1);
      store_word(5'd7, 12'h100, "load_add", fill_word(DATA_BASE + 32'h100) + 32'd1);
      end_pc = asm_pc;
      emit(enc_j(21'd0, 5'd0), 1'b1);
   endtask

   task automatic report_mismatch(input string sig, input logic [31:0] got,
                                  input logic [31:0] exp);
      errs++;
      $display("ERR t=%0t %s got 0x%08h exp 0x%08h", $time, sig, got, exp);
   endtask

   task automatic finish_test(input string name, input bit ok);
      tests_run++;
      if (!ok) begin
         tests_failed++;
      end
      $display("test %-12s %s", name, ok ? "ok" : "failed");
   endtask

   task automatic check_fetch(input logic [31:0] adr);
      logic [31:0] exp;
      if (!fetch_seen) begin
         assert (adr == `BITCORE_RESET_PC) else begin
            report_mismatch("o_ibus.adr", adr, `BITCORE_RESET_PC);
            reset_errs++;
         end
         fetch_seen = 1'b1;
      end
      if (fetch_q.size() > 0) begin
         exp = fetch_q.pop_front();
         assert (adr == exp) else begin
            report_mismatch("o_ibus.adr", adr, exp);
            fetch_errs++;
         end
      end else if (!done) begin
         // Second fetch of the closing jump to itself
         assert (adr == end_pc) else begin
            report_mismatch("o_ibus.adr", adr, end_pc);
            fetch_errs++;
         end
         done = 1'b1;
         finish_test("fetch_order", fetch_errs == 0);
      end
   endtask

   task automatic check_store(input bitcore_bus_pkg::dbus_req_t req);
      store_t exp;
      string  name;
      int     errs_before;
      if (stores_seen == 0) begin
         finish_test("reset", reset_errs == 0);
      end
      assert (store_q.size() > 0) else begin
         $display("unexpected store to 0x%08h after all expected stores", req.adr);
         errs++;
      end
      if (store_q.size() > 0) begin
         errs_before = errs;
         exp = store_q.pop_front();
         name = name_q.pop_front();
         assert (req.adr == exp.adr) else report_mismatch("o_dbus.adr", req.adr, exp.adr);
         assert (req.dat == exp.dat) else report_mismatch("o_dbus.dat", req.dat, exp.dat);
         finish_test(name, errs == errs_before);
      end
      stores_seen++;
      dram[req.adr[9:2]] = req.dat;
   endtask

   always @(negedge clk) begin
      if (!rst_n) begin
         ibus_ack = 1'b0;
         ibus_wait = -1;
      end else if (ibus_ack) begin
         ibus_ack = 1'b0;
      end else if (ibus_req.cyc) begin
         if (ibus_wait < 0) begin
            ibus_wait = int'(draw_delay());
         end
         if (ibus_wait == 0) begin
            check_fetch(ibus_req.adr);
            ibus_rdt = rom[ibus_req.adr[7:2]];
            ibus_ack = 1'b1;
            ibus_wait = -1;
         end else begin
            ibus_wait--;
         end
      end
   end

   always @(negedge clk) begin
      if (!rst_n) begin
         dbus_ack = 1'b0;
         dbus_wait = -1;
      end else begin
         assert (stores_seen > 0 || !dbus_req.cyc || dbus_req.we) else begin
            $display("data read issued before the first store at t=%0t", $time);
            errs++;
            reset_errs++;
         end
         if (dbus_ack) begin
            dbus_ack = 1'b0;
         end else if (dbus_req.cyc) begin
            if (dbus_wait < 0) begin
               dbus_wait = int'(draw_delay());
            end
            if (dbus_wait == 0) begin
               if (dbus_req.we) begin
                  check_store(dbus_req);
               end else begin
                  dbus_rdt = dram[dbus_req.adr[9:2]];
               end
               dbus_ack = 1'b1;
               dbus_wait = -1;
            end else begin
               dbus_wait--;
            end
         end
      end
   end

   initial begin
      wait (limit_cycles > 0);
      repeat (limit_cycles) @(posedge clk);
      $display("watchdog expired after %0d cycles, program did not finish", limit_cycles);
      $display("TESTS FAILED");
      $finish;
   end

   initial begin
      build_program();
      // Twice the fetch count times 40 cycles times the worst ack wait
      limit_cycles = fetch_q.size() * 40 * (MAX_ACK_DELAY + 1) * 2 + 10;
      repeat (10) @(negedge clk);
      rst_n = 1'b1;
      wait (done);
      repeat (4) @(negedge clk);
      prop_fails = int'(bitcore_top_i.props_i.fail_cnt);
      errs += prop_fails;
      finish_test("bus_protocol", prop_fails == 0);
      assert (store_q.size() == 0) else begin
         $display("%0d expected stores never reached the data bus", store_q.size());
         errs++;
      end
      $display("tests run %0d, passed %0d, failed %0d, errors %0d",
               tests_run, tests_run - tests_failed, tests_failed, errs);
      if (errs == 0 && tests_failed == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+hw
hw/bitcore_isa_pkg.sv
hw/bitcore_bus_pkg.sv
hw/bitcore_decode.sv
hw/bitcore_regfile.sv
hw/bitcore_alu.sv
hw/bitcore_ctrl.sv
hw/bitcore_mem_if.sv
hw/bitcore_top.sv
sim/bitcore_properties.sv
sim/bitcore_tb.sv
